// ==== src/soc_io_consts.svh ====
`ifndef SOC_IO_CONSTS_SVH
`define SOC_IO_CONSTS_SVH

// ---------------------------------------------------------------------
// Device I/O system constants
// ---------------------------------------------------------------------

// Processor word, both address and data
`define SOC_XLEN 32

// Register address width of the SD-card SPI controller
`define SOC_AXI_ADDR_W 7

// Extra cycles the system reset is held after the user reset drops
`define SOC_RST_STRETCH 5

// Device windows, selected by the top address byte
`define SOC_UART_PAGE 8'hC0  // 0xC000_0000 - 0xC0FF_FFFF
`define SOC_SPI_PAGE  8'hC2  // 0xC200_0000 - 0xC2FF_FFFF

// Width of the page field
`define SOC_PAGE_W 8

`endif

// ==== src/soc_io_pkg.sv ====
`default_nettype none

`include "soc_io_consts.svh"

package soc_io_pkg;

    // Word types of the device bus
    typedef logic [`SOC_XLEN-1:0]   xlen_t;     // Address or data word
    typedef logic [`SOC_XLEN/8-1:0] byte_en_t;  // One enable per byte lane

    // AXI4-Lite side
    typedef logic [`SOC_AXI_ADDR_W-1:0] axi_addr_t;  // Register offset in the controller
    typedef logic [1:0]                 axi_resp_t;  // OKAY, EXOKAY, SLVERR, DECERR

    // Window decode
    typedef logic [`SOC_PAGE_W-1:0] dev_page_t;  // Top address byte
    typedef logic [1:0]             uart_reg_t;  // Address bits 3 and 2

endpackage

`default_nettype wire

// ==== src/dev_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// One slave port of the processor device bus
interface dev_bus_if;
    import soc_io_pkg::*;

    logic     strobe;  // One-cycle request pulse
    xlen_t    addr;    // Held until ready
    logic     we;      // 1 = write
    byte_en_t be;
    xlen_t    wdata;
    xlen_t    rdata;   // Valid only with ready
    logic     ready;   // One-cycle completion pulse

    // Decoder side, next strobe only after ready
    modport master (
        output strobe, addr, we, be, wdata,
        input  rdata, ready
    );

    // Device side
    modport slave (
        input  strobe, addr, we, be, wdata,
        output rdata, ready
    );

endinterface

`default_nettype wire

// ==== src/io_reset_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_io_consts.svh"

// Stretches the user reset so short button presses still clear the system
module io_reset_gen (
    input  wire  clk,
    input  wire  usr_reset,
    output logic rst_o
);

    logic [`SOC_RST_STRETCH-1:0] rst_sr;  // Ones shift out toward the MSB

    // ---------------------------------------------------------------------
    // Shift register
    // ---------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (usr_reset) begin
            rst_sr <= '1;                                       // Reload while held
        end else begin
            rst_sr <= {rst_sr[`SOC_RST_STRETCH-2:0], 1'b0};     // Shift in zeros
        end
    end

    // High as soon as the user reset rises, low after the last one leaves
    // the MSB, which is SOC_RST_STRETCH edges after usr_reset drops
    assign rst_o = usr_reset | rst_sr[`SOC_RST_STRETCH-1];

endmodule

`default_nettype wire

// ==== src/dev_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_io_consts.svh"

// Device window decode: UART at page C0, SPI bridge at page C2
module dev_decoder (
    // Processor device bus
    input  wire                        dev_strobe_i,
    input  wire soc_io_pkg::xlen_t     dev_addr_i,
    input  wire                        dev_we_i,
    input  wire soc_io_pkg::byte_en_t  dev_be_i,
    input  wire soc_io_pkg::xlen_t     dev_wdata_i,
    output soc_io_pkg::xlen_t          dev_rdata_o,
    output logic                       dev_ready_o,

    // UART register port
    output logic                       uart_en_o,
    output soc_io_pkg::uart_reg_t      uart_reg_o,
    output logic                       uart_we_o,
    output soc_io_pkg::byte_en_t       uart_be_o,
    output soc_io_pkg::xlen_t          uart_wdata_o,
    input  wire soc_io_pkg::xlen_t     uart_rdata_i,
    input  wire                        uart_ready_i,

    // Toward the AXI bridge
    dev_bus_if.master                  spi_bus
);
    import soc_io_pkg::*;

    dev_page_t page;      // Top address byte
    logic      uart_sel;
    logic      spi_sel;

    // ---------------------------------------------------------------------
    // Window select
    // ---------------------------------------------------------------------
    assign page     = dev_addr_i[`SOC_XLEN-1 -: `SOC_PAGE_W];
    assign uart_sel = (page == dev_page_t'(`SOC_UART_PAGE));
    assign spi_sel  = (page == dev_page_t'(`SOC_SPI_PAGE));

    // UART gets the strobe only inside its window
    assign uart_en_o    = dev_strobe_i & uart_sel;
    assign uart_reg_o   = dev_addr_i[3:2];   // Word index of the 4 registers
    assign uart_we_o    = dev_we_i;
    assign uart_be_o    = dev_be_i;
    assign uart_wdata_o = dev_wdata_i;

    // Same steering for the SPI side
    assign spi_bus.strobe = dev_strobe_i & spi_sel;
    assign spi_bus.addr   = dev_addr_i;  // Bridge keeps the low bits
    assign spi_bus.we     = dev_we_i;
    assign spi_bus.be     = dev_be_i;
    assign spi_bus.wdata  = dev_wdata_i;

    // ---------------------------------------------------------------------
    // Return path
    // ---------------------------------------------------------------------
    always_comb begin
        if (uart_sel) begin
            dev_rdata_o = uart_rdata_i;
            dev_ready_o = uart_ready_i;
        end else if (spi_sel) begin
            dev_rdata_o = spi_bus.rdata;
            dev_ready_o = spi_bus.ready;
        end else begin
            dev_rdata_o = '0;    // Unmapped page never completes
            dev_ready_o = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== src/dev_axi_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_io_consts.svh"

// Device bus slave to AXI4-Lite master, one transaction at a time
module dev_axi_bridge (
    input  wire                         clk,
    input  wire                         rst_i,
    dev_bus_if.slave                    spi_bus,

    // Write address channel
    output soc_io_pkg::axi_addr_t       axi_awaddr_o,
    output logic                        axi_awvalid_o,
    input  wire                         axi_awready_i,
    // Write data channel
    output soc_io_pkg::xlen_t           axi_wdata_o,
    output soc_io_pkg::byte_en_t        axi_wstrb_o,
    output logic                        axi_wvalid_o,
    input  wire                         axi_wready_i,
    // Write response channel
    input  wire soc_io_pkg::axi_resp_t  axi_bresp_i,
    input  wire                         axi_bvalid_i,
    output logic                        axi_bready_o,
    // Read address channel
    output soc_io_pkg::axi_addr_t       axi_araddr_o,
    output logic                        axi_arvalid_o,
    input  wire                         axi_arready_i,
    // Read data channel
    input  wire soc_io_pkg::xlen_t      axi_rdata_i,
    input  wire soc_io_pkg::axi_resp_t  axi_rresp_i,
    input  wire                         axi_rvalid_i,
    output logic                        axi_rready_o
);
    import soc_io_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,        // Waiting for a strobe
        S_WR_ADDR,     // AW and W outstanding
        S_WR_RESP,     // Waiting for B
        S_RD_ADDR,     // AR outstanding
        S_RD_RESP,     // Waiting for R
        S_DONE         // Ready pulse back to the device bus
    } state_t;

    state_t    state_q;
    logic      aw_pend_q;   // AW not yet accepted
    logic      w_pend_q;    // W not yet accepted
    logic      ar_pend_q;   // AR not yet accepted
    logic      aw_done;
    logic      w_done;

    axi_addr_t addr_q;      // Register offset of the request
    xlen_t     wdata_q;
    byte_en_t  be_q;
    xlen_t     rdata_q;     // Zero after a write
    axi_resp_t resp_q;      // Last B or R response

    // AW and W finish independently, either one may already be gone
    assign aw_done = ~aw_pend_q | axi_awready_i;
    assign w_done  = ~w_pend_q | axi_wready_i;

    // ---------------------------------------------------------------------
    // Control FSM
    // ---------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q   <= S_IDLE;
            aw_pend_q <= 1'b0;
            w_pend_q  <= 1'b0;
            ar_pend_q <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (spi_bus.strobe) begin
                        if (spi_bus.we) begin
                            state_q   <= S_WR_ADDR;
                            aw_pend_q <= 1'b1;   // Both valids rise together
                            w_pend_q  <= 1'b1;
                        end else begin
                            state_q   <= S_RD_ADDR;
                            ar_pend_q <= 1'b1;
                        end
                    end
                end
                S_WR_ADDR: begin
                    if (axi_awready_i) aw_pend_q <= 1'b0;
                    if (axi_wready_i)  w_pend_q  <= 1'b0;
                    if (aw_done && w_done) state_q <= S_WR_RESP;
                end
                S_WR_RESP: begin
                    if (axi_bvalid_i) state_q <= S_DONE;  // bready is high here
                end
                S_RD_ADDR: begin
                    if (axi_arready_i) begin
                        ar_pend_q <= 1'b0;
                        state_q   <= S_RD_RESP;
                    end
                end
                S_RD_RESP: begin
                    if (axi_rvalid_i) state_q <= S_DONE;  // rready is high here
                end
                S_DONE:  state_q <= S_IDLE;
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // ---------------------------------------------------------------------
    // Payload capture
    // ---------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && spi_bus.strobe) begin
            addr_q  <= spi_bus.addr[`SOC_AXI_ADDR_W-1:0];  // Low bits only
            wdata_q <= spi_bus.wdata;
            be_q    <= spi_bus.be;
        end
        if (state_q == S_WR_RESP && axi_bvalid_i) begin
            rdata_q <= '0;
            resp_q  <= axi_bresp_i;
        end
        if (state_q == S_RD_RESP && axi_rvalid_i) begin
            rdata_q <= axi_rdata_i;
            resp_q  <= axi_rresp_i;
        end
    end

    // AXI outputs, held stable while the valids wait
    assign axi_awaddr_o  = addr_q;
    assign axi_awvalid_o = aw_pend_q;
    assign axi_wdata_o   = wdata_q;
    assign axi_wstrb_o   = be_q;
    assign axi_wvalid_o  = w_pend_q;
    assign axi_bready_o  = (state_q == S_WR_RESP);
    assign axi_araddr_o  = addr_q;
    assign axi_arvalid_o = ar_pend_q;
    assign axi_rready_o  = (state_q == S_RD_RESP);

    // Completion, SLVERR and DECERR give back zero
    assign spi_bus.ready = (state_q == S_DONE);
    assign spi_bus.rdata = resp_q[1] ? '0 : rdata_q;

endmodule

`default_nettype wire

// ==== src/soc_io_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// Device I/O slice: reset stretcher, window decoder and SPI-side AXI bridge
module soc_io_top (
    input  wire                         clk,
    input  wire                         usr_reset,

    // Processor device bus
    input  wire                         dev_strobe_i,
    input  wire soc_io_pkg::xlen_t      dev_addr_i,
    input  wire                         dev_we_i,
    input  wire soc_io_pkg::byte_en_t   dev_be_i,
    input  wire soc_io_pkg::xlen_t      dev_wdata_i,
    output soc_io_pkg::xlen_t           dev_rdata_o,
    output logic                        dev_ready_o,

    // UART register port
    output logic                        uart_en_o,
    output soc_io_pkg::uart_reg_t       uart_reg_o,
    output logic                        uart_we_o,
    output soc_io_pkg::byte_en_t        uart_be_o,
    output soc_io_pkg::xlen_t           uart_wdata_o,
    input  wire soc_io_pkg::xlen_t      uart_rdata_i,
    input  wire                         uart_ready_i,

    // AXI4-Lite master toward the SD-card SPI controller
    output soc_io_pkg::axi_addr_t       axi_awaddr_o,
    output logic                        axi_awvalid_o,
    input  wire                         axi_awready_i,
    output soc_io_pkg::xlen_t           axi_wdata_o,
    output soc_io_pkg::byte_en_t        axi_wstrb_o,
    output logic                        axi_wvalid_o,
    input  wire                         axi_wready_i,
    input  wire soc_io_pkg::axi_resp_t  axi_bresp_i,
    input  wire                         axi_bvalid_i,
    output logic                        axi_bready_o,
    output soc_io_pkg::axi_addr_t       axi_araddr_o,
    output logic                        axi_arvalid_o,
    input  wire                         axi_arready_i,
    input  wire soc_io_pkg::xlen_t      axi_rdata_i,
    input  wire soc_io_pkg::axi_resp_t  axi_rresp_i,
    input  wire                         axi_rvalid_i,
    output logic                        axi_rready_o,

    // Stretched system reset
    output logic                        rst_o
);

    logic      sys_rst;   // Stretched reset for the whole slice
    dev_bus_if spi_bus(); // Decoder to bridge

    // ---------------------------------------------------------------------
    // Reset and decode
    // ---------------------------------------------------------------------
    io_reset_gen i_io_reset_gen (.clk(clk), .usr_reset(usr_reset), .rst_o(sys_rst));

    assign rst_o = sys_rst;  // Shared with the external controllers

    dev_decoder i_dev_decoder (
        .dev_strobe_i (dev_strobe_i),  .dev_addr_i   (dev_addr_i),
        .dev_we_i     (dev_we_i),      .dev_be_i     (dev_be_i),
        .dev_wdata_i  (dev_wdata_i),   .dev_rdata_o  (dev_rdata_o),
        .dev_ready_o  (dev_ready_o),   .uart_en_o    (uart_en_o),
        .uart_reg_o   (uart_reg_o),    .uart_we_o    (uart_we_o),
        .uart_be_o    (uart_be_o),     .uart_wdata_o (uart_wdata_o),
        .uart_rdata_i (uart_rdata_i),  .uart_ready_i (uart_ready_i),
        .spi_bus      (spi_bus)
    );

    // ---------------------------------------------------------------------
    // SPI window bridge
    // ---------------------------------------------------------------------
    dev_axi_bridge i_dev_axi_bridge (
        .clk           (clk),            .rst_i         (sys_rst),
        .spi_bus       (spi_bus),
        .axi_awaddr_o  (axi_awaddr_o),   .axi_awvalid_o (axi_awvalid_o),
        .axi_awready_i (axi_awready_i),  .axi_wdata_o   (axi_wdata_o),
        .axi_wstrb_o   (axi_wstrb_o),    .axi_wvalid_o  (axi_wvalid_o),
        .axi_wready_i  (axi_wready_i),   .axi_bresp_i   (axi_bresp_i),
        .axi_bvalid_i  (axi_bvalid_i),   .axi_bready_o  (axi_bready_o),
        .axi_araddr_o  (axi_araddr_o),   .axi_arvalid_o (axi_arvalid_o),
        .axi_arready_i (axi_arready_i),  .axi_rdata_i   (axi_rdata_i),
        .axi_rresp_i   (axi_rresp_i),    .axi_rvalid_i  (axi_rvalid_i),
        .axi_rready_o  (axi_rready_o)
    );

endmodule

`default_nettype wire

// ==== verif/soc_io_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_io_consts.svh"

// Watches the DUT ports, keeps shadow registers and counts errors
module soc_io_checker (
    input  wire         clk,
    input  wire         usr_reset,
    input  wire         rst_o,
    input  wire         dev_strobe_i, dev_we_i, dev_ready_o,
    input  wire  [31:0] dev_addr_i, dev_wdata_i, dev_rdata_o,
    input  wire  [3:0]  dev_be_i,
    input  wire         uart_en_o, uart_we_o, uart_ready_i,
    input  wire  [1:0]  uart_reg_o,
    input  wire  [3:0]  uart_be_o,
    input  wire  [31:0] uart_wdata_o,
    input  wire  [6:0]  axi_awaddr_o, axi_araddr_o,
    input  wire  [31:0] axi_wdata_o,
    input  wire  [3:0]  axi_wstrb_o,
    input  wire         axi_awvalid_o, axi_awready_i, axi_wvalid_o, axi_wready_i,
    input  wire         axi_bvalid_i, axi_bready_o, axi_arvalid_o, axi_arready_i,
    input  wire         axi_rvalid_i, axi_rready_o,
    output int          error_count,
    output int          check_count
);

    logic [31:0] uart_shadow [4] = '{default: '0};
    logic [31:0] axi_shadow [32] = '{default: '0};
    logic [31:0] req_addr, req_wdata;
    logic [3:0]  req_be;
    logic        req_we;
    logic        pending = 1'b0;    // Request not yet answered
    logic        started = 1'b0;    // Past the first edge
    logic        resp_hs = 1'b0;    // B or R handshake on the previous edge
    logic        aw_wait = 1'b0, w_wait = 1'b0, ar_wait = 1'b0;   // Valid left unaccepted
    logic [6:0]  aw_prev, ar_prev;
    logic [31:0] w_prev;
    int          low_edges = 0;     // Edges that sampled usr_reset low
    int          aw_n, w_n, ar_n;

    initial begin
        error_count = 0;
        check_count = 0;
    end

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        check_count++;
        if (act !== exp) begin
            error_count++;
            $display("mismatch time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
        end
    endtask

    task automatic report_error(input string what);
        error_count++;
        $display("error at time %0t: %s", $time, what);
    endtask

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0] be);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    // Expected read data from window and address
    function automatic logic [31:0] expected_read(input logic [31:0] addr);
        if (addr[31:24] == `SOC_UART_PAGE) return uart_shadow[addr[3:2]];
        if (addr[31:24] == `SOC_SPI_PAGE) return axi_shadow[addr[6:2]];
        return '0;
    endfunction

    function automatic bit is_mapped(input logic [31:0] addr);
        return addr[31:24] == `SOC_UART_PAGE || addr[31:24] == `SOC_SPI_PAGE;
    endfunction

    always @(posedge clk) begin
        // ------------------------------------------------------------------
        // Reset stretch and quiet outputs
        // ------------------------------------------------------------------
        compare("rst_o", 32'(usr_reset || low_edges < `SOC_RST_STRETCH), 32'(rst_o));
        low_edges = usr_reset ? 0 : (low_edges < 100 ? low_edges + 1 : low_edges);
        if (started && (rst_o || !pending)) begin
            compare("axi_awvalid_o", 0, 32'(axi_awvalid_o));   // Nothing outstanding
            compare("axi_wvalid_o", 0, 32'(axi_wvalid_o));
            compare("axi_arvalid_o", 0, 32'(axi_arvalid_o));
            compare("axi_bready_o", 0, 32'(axi_bready_o));
            compare("axi_rready_o", 0, 32'(axi_rready_o));
        end
        started = 1'b1;

        // New request and UART enable only in its window
        if (dev_strobe_i) begin
            pending = 1'b1;
            {req_addr, req_we, req_be, req_wdata} = {dev_addr_i, dev_we_i, dev_be_i, dev_wdata_i};
            aw_n = 0;
            w_n  = 0;
            ar_n = 0;
        end
        compare("uart_en_o", 32'(dev_strobe_i && dev_addr_i[31:24] == `SOC_UART_PAGE),
                32'(uart_en_o));
        if (uart_en_o) begin
            compare("uart_reg_o", 32'(dev_addr_i[3:2]), 32'(uart_reg_o));
            compare("uart_we_o", 32'(dev_we_i), 32'(uart_we_o));
            compare("uart_be_o", 32'(dev_be_i), 32'(uart_be_o));
            compare("uart_wdata_o", dev_wdata_i, uart_wdata_o);
            if (uart_we_o) uart_shadow[uart_reg_o] = merge_bytes(uart_shadow[uart_reg_o],
                                                                 uart_wdata_o, uart_be_o);
        end
        if (pending && !is_mapped(req_addr) && (axi_awvalid_o || axi_arvalid_o || dev_ready_o))
            report_error("response to an unmapped page");
        if (pending && req_addr[31:24] == `SOC_UART_PAGE)
            compare("dev_ready_o", 32'(uart_ready_i), 32'(dev_ready_o));

        // ------------------------------------------------------------------
        // AXI channels stay stable until accepted
        // ------------------------------------------------------------------
        if (aw_wait) compare("axi_awaddr_o", 32'(aw_prev), 32'(axi_awaddr_o));
        if (aw_wait) compare("axi_awvalid_o", 1, 32'(axi_awvalid_o));
        if (w_wait) compare("axi_wdata_o", w_prev, axi_wdata_o);
        if (w_wait) compare("axi_wvalid_o", 1, 32'(axi_wvalid_o));
        if (ar_wait) compare("axi_araddr_o", 32'(ar_prev), 32'(axi_araddr_o));
        if (ar_wait) compare("axi_arvalid_o", 1, 32'(axi_arvalid_o));
        if (axi_awvalid_o && axi_awready_i) begin
            aw_n++;
            compare("axi_awaddr_o", 32'(req_addr[6:0]), 32'(axi_awaddr_o));
        end
        if (axi_wvalid_o && axi_wready_i) begin
            w_n++;
            compare("axi_wdata_o", req_wdata, axi_wdata_o);
            compare("axi_wstrb_o", 32'(req_be), 32'(axi_wstrb_o));
            axi_shadow[axi_awaddr_o[6:2]] = merge_bytes(axi_shadow[axi_awaddr_o[6:2]],
                                                        axi_wdata_o, axi_wstrb_o);
        end
        if (axi_arvalid_o && axi_arready_i) begin
            ar_n++;
            compare("axi_araddr_o", 32'(req_addr[6:0]), 32'(axi_araddr_o));
        end
        aw_wait = axi_awvalid_o && !axi_awready_i;
        w_wait  = axi_wvalid_o && !axi_wready_i;
        ar_wait = axi_arvalid_o && !axi_arready_i;
        aw_prev = axi_awaddr_o;
        w_prev  = axi_wdata_o;
        ar_prev = axi_araddr_o;

        // Completion with one ready per request
        if (resp_hs) compare("dev_ready_o", 1, 32'(dev_ready_o));   // One cycle after B or R
        resp_hs = (axi_bvalid_i && axi_bready_o) || (axi_rvalid_i && axi_rready_o);
        if (dev_ready_o) begin
            if (!pending) report_error("dev_ready_o without an outstanding request");
            else if (!req_we) compare("dev_rdata_o", expected_read(req_addr), dev_rdata_o);
            if (pending && req_addr[31:24] == `SOC_SPI_PAGE) begin
                compare("aw_handshakes", 32'(req_we), aw_n);
                compare("w_handshakes", 32'(req_we), w_n);
                compare("ar_handshakes", 32'(!req_we), ar_n);
            end
            pending = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_soc_io_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "soc_io_consts.svh"

module tb_soc_io_top;

    localparam int NUM_REQ   = 80;   // Processor requests
    localparam int TIMEOUT   = 200;  // Cycles allowed for any single wait
    localparam int IDLE_WAIT = 32;   // Unmapped strobes must stay silent this long

    logic clk = 1'b0;
    logic usr_reset = 1'b1;
    int   seed = 32'hdc421c1b;
    int   uart_seed = 32'hdc421c1b ^ 32'h1;   // One stream per model
    int   axi_seed = 32'hdc421c1b ^ 32'h2;
    int   error_count;
    int   check_count;
    int   timeout_count = 0;

    // Processor side
    logic dev_strobe_i = 1'b0, dev_we_i = 1'b0;
    logic [31:0] dev_addr_i = '0, dev_wdata_i = '0;
    logic [3:0] dev_be_i = '0;
    logic [31:0] dev_rdata_o;
    logic dev_ready_o;

    // UART register port and its model
    logic uart_en_o, uart_we_o;
    logic [1:0] uart_reg_o;
    logic [3:0] uart_be_o;
    logic [31:0] uart_wdata_o;
    logic [31:0] uart_rdata_i = '0;
    logic uart_ready_i = 1'b0;
    logic [31:0] uart_regs [4] = '{default: '0};
    logic [1:0] uart_idx = '0;
    logic [2:0] uart_dly = '0;
    logic uart_busy = 1'b0;

    // AXI4-Lite port and its slave model
    logic [6:0] axi_awaddr_o, axi_araddr_o;
    logic [31:0] axi_wdata_o;
    logic [3:0] axi_wstrb_o;
    logic axi_awvalid_o, axi_wvalid_o, axi_bready_o, axi_arvalid_o, axi_rready_o;
    logic axi_awready_i = 1'b0, axi_wready_i = 1'b0, axi_arready_i = 1'b0;
    logic axi_bvalid_i = 1'b0, axi_rvalid_i = 1'b0;
    logic [1:0] axi_bresp_i = 2'b00, axi_rresp_i = 2'b00;   // Always OKAY
    logic [31:0] axi_rdata_i = '0;
    logic rst_o;
    logic [31:0] axi_mem [32] = '{default: '0};
    logic [2:0] aw_dly = '0, w_dly = '0, ar_dly = '0, b_dly = '0, r_dly = '0;
    logic [6:0] aw_q = '0, ar_q = '0;
    logic [31:0] wd_q = '0;
    logic [3:0] ws_q = '0;
    logic aw_have = 1'b0, w_have = 1'b0, b_pend = 1'b0, r_pend = 1'b0;

    always #4 clk = ~clk;   // 8 ns period

    soc_io_top i_soc_io_top (.*);

    soc_io_checker i_soc_io_checker (.*);

    function automatic logic [31:0] apply_strobes(input logic [31:0] old_w,
                                                  input logic [31:0] new_w,
                                                  input logic [3:0] be);
        logic [31:0] res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) res[8*b +: 8] = new_w[8*b +: 8];
        end
        return res;
    endfunction

    // ---------------------------------------------------------------------
    // UART model with 4 registers and 0 to 3 extra cycles
    // ---------------------------------------------------------------------
    always @(posedge clk) begin
        uart_ready_i <= 1'b0;
        if (uart_en_o && !uart_busy) begin
            if (uart_we_o) uart_regs[uart_reg_o] <= apply_strobes(uart_regs[uart_reg_o],
                                                                  uart_wdata_o, uart_be_o);
            uart_idx  <= uart_reg_o;
            uart_dly  <= 3'($unsigned($random(uart_seed)) % 4);
            uart_busy <= 1'b1;
        end else if (uart_busy) begin
            if (uart_dly == 0) begin
                uart_ready_i <= 1'b1;
                uart_rdata_i <= uart_regs[uart_idx];   // Already holds a write
                uart_busy    <= 1'b0;
            end else begin
                uart_dly <= uart_dly - 1;
            end
        end
    end

    // ---------------------------------------------------------------------
    // AXI4-Lite slave model with 32 words and independent random delays
    // ---------------------------------------------------------------------
    always @(posedge clk) begin
        if (axi_awready_i) begin
            axi_awready_i <= 1'b0;                         // Handshake this edge
            aw_q <= axi_awaddr_o;
            aw_have <= 1'b1;
            aw_dly <= 3'($unsigned($random(axi_seed)) % 5);
        end else if (axi_awvalid_o) begin
            if (aw_dly == 0) axi_awready_i <= 1'b1;
            else aw_dly <= aw_dly - 1;
        end
        if (axi_wready_i) begin
            axi_wready_i <= 1'b0;
            wd_q <= axi_wdata_o;
            ws_q <= axi_wstrb_o;
            w_have <= 1'b1;
            w_dly <= 3'($unsigned($random(axi_seed)) % 5);
        end else if (axi_wvalid_o) begin
            if (w_dly == 0) axi_wready_i <= 1'b1;
            else w_dly <= w_dly - 1;
        end
        if (aw_have && w_have && !b_pend) begin
            axi_mem[aw_q[6:2]] <= apply_strobes(axi_mem[aw_q[6:2]], wd_q, ws_q);
            aw_have <= 1'b0;
            w_have <= 1'b0;
            b_pend <= 1'b1;
            b_dly <= 3'($unsigned($random(axi_seed)) % 5);
        end
        if (b_pend) begin
            if (axi_bvalid_i && axi_bready_o) begin
                axi_bvalid_i <= 1'b0;
                b_pend <= 1'b0;
            end else if (!axi_bvalid_i) begin
                if (b_dly == 0) axi_bvalid_i <= 1'b1;
                else b_dly <= b_dly - 1;
            end
        end
        if (axi_arready_i) begin
            axi_arready_i <= 1'b0;
            ar_q <= axi_araddr_o;
            r_pend <= 1'b1;
            r_dly <= 3'($unsigned($random(axi_seed)) % 5);
        end else if (axi_arvalid_o && !r_pend) begin
            if (ar_dly == 0) axi_arready_i <= 1'b1;
            else ar_dly <= ar_dly - 1;
        end
        if (r_pend) begin
            if (axi_rvalid_i && axi_rready_o) begin
                axi_rvalid_i <= 1'b0;
                r_pend <= 1'b0;
                ar_dly <= 3'($unsigned($random(axi_seed)) % 5);
            end else if (!axi_rvalid_i) begin
                if (r_dly == 0) begin
                    axi_rvalid_i <= 1'b1;
                    axi_rdata_i <= axi_mem[ar_q[6:2]];
                end else begin
                    r_dly <= r_dly - 1;
                end
            end
        end
    end

    // Records a stuck wait so no further requests go out
    task automatic note_timeout(input string what);
        $display("timeout waiting for %s", what);
        timeout_count++;
    endtask

    // One processor access, held until ready or for IDLE_WAIT on unmapped pages
    task automatic issue_request(input logic [31:0] addr, input logic we,
                                 input logic [3:0] be, input logic [31:0] wdata,
                                 input bit mapped);
        int n;
        n = 0;
        @(posedge clk);
        dev_strobe_i <= 1'b1;
        dev_addr_i   <= addr;
        dev_we_i     <= we;
        dev_be_i     <= be;
        dev_wdata_i  <= wdata;
        @(posedge clk);
        dev_strobe_i <= 1'b0;
        if (mapped) begin
            while (!dev_ready_o && n < TIMEOUT) begin
                @(posedge clk);
                n++;
            end
            if (!dev_ready_o) note_timeout("dev_ready_o");
        end else begin
            while (n < IDLE_WAIT) begin   // No response expected
                @(posedge clk);
                n++;
            end
        end
    endtask

    // ---------------------------------------------------------------------
    // Processor side
    // ---------------------------------------------------------------------
    initial begin
        int n;
        int sel;
        logic [31:0] rnd;
        logic [7:0] page;
        n = 0;
        repeat (10) @(posedge clk);
        usr_reset <= 1'b0;
        while (rst_o !== 1'b0 && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (rst_o !== 1'b0) note_timeout("rst_o to fall");
        for (int i = 0; i < NUM_REQ && timeout_count == 0; i++) begin
            sel  = $unsigned($random(seed)) % 10;
            rnd  = $random(seed);
            page = (sel < 4) ? `SOC_UART_PAGE : (sel < 9) ? `SOC_SPI_PAGE : rnd[31:24];
            if (sel >= 9 && (page == `SOC_UART_PAGE || page == `SOC_SPI_PAGE)) page = 8'hC1;
            issue_request({page, rnd[23:0]}, rnd[31], 4'($random(seed)), $random(seed),
                          sel < 9);
        end
        repeat (4) @(posedge clk);
        $display("closing: %0d checks, %0d errors, %0d timeouts",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== soc_io.f ====
+incdir+src
src/soc_io_pkg.sv
src/dev_bus_if.sv
src/io_reset_gen.sv
src/dev_decoder.sv
src/dev_axi_bridge.sv
src/soc_io_top.sv
verif/soc_io_checker.sv
verif/tb_soc_io_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the soc_io testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f soc_io.f --top-module tb_soc_io_top -o sim_soc_io

./obj_dir/sim_soc_io > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
grep -q "TEST PASS" sim.log
